// ==== files.f ====
source/core_pkg.sv
source/cache_pkg.sv
source/pipe_if.sv
source/ifu.sv
source/decode.sv
source/execute.sv
source/result.sv
source/core_top.sv
tb/imem_model.sv
tb/tb_core.sv

// ==== tb/tb_core.sv ====
`timescale 1ns/1ns

module tb_core;

  localparam int TIMEOUT = 2000;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] data;
  } retire_t;

  logic        clk;
  logic        rst;
  logic [31:0] imem_araddr;
  logic        imem_arvalid;
  logic [31:0] imem_rdata;
  logic        imem_rvalid;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;

  retire_t     exp_q [$];
  string       test_name;
  logic [31:0] wr_pc;
  logic [31:0] line_base;
  logic        second_word;
  int          bus_reads;
  int          mismatches;
  int          timeouts;

  core_top u_core_top (
    .clk            (clk),
    .rst            (rst),
    .imem_araddr_o  (imem_araddr),
    .imem_arvalid_o (imem_arvalid),
    .imem_rdata_i   (imem_rdata),
    .imem_rvalid_i  (imem_rvalid),
    .retire_valid_o (retire_valid),
    .retire_pc_o    (retire_pc),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data)
  );

  imem_model u_imem (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (imem_araddr),
    .arvalid_i (imem_arvalid),
    .rdata_o   (imem_rdata),
    .rvalid_o  (imem_rvalid)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] itype(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return itype(7'b0010011, rd, 3'b000, rs1, imm);
  endfunction

  function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("mismatch %s %s: expected 0x%h, actual 0x%h", test_name, what, expected, actual);
    mismatches++;
  endtask

  task automatic put(input logic [31:0] inst);
    u_imem.write_word(wr_pc, inst);
    wr_pc = wr_pc + 32'd4;
  endtask

  task automatic expect_retire(input logic [31:0] pc, input logic [4:0] rd,
                               input logic [31:0] data);
    exp_q.push_back({pc, rd, data});
  endtask

  // Straight-line instruction that must retire.
  task automatic step(input logic [31:0] inst, input logic [4:0] rd, input logic [31:0] data);
    expect_retire(wr_pc, rd, data);
    put(inst);
  endtask

  task automatic begin_test(input string name);
    @(negedge clk);
    rst = 1'b1;
    test_name = name;
    exp_q.delete();
    wr_pc = 32'd0;
  endtask

  task automatic release_reset();
    repeat (2) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic wait_retire_pc(input logic [31:0] pc);
    int cycles;
    cycles = 0;
    while (cycles < TIMEOUT && !(retire_valid && retire_pc == pc)) begin
      @(negedge clk);
      cycles++;
    end
    if (!(retire_valid && retire_pc == pc)) begin
      $display("timeout in %s: pc 0x%h never retired", test_name, pc);
      timeouts++;
    end
  endtask

  // Negative exp_reads skips the bus read count.
  task automatic drain(input int exp_reads);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout in %s: %0d expected retires never came", test_name, exp_q.size());
      timeouts++;
    end
    if (exp_reads >= 0) begin
      assert (bus_reads == exp_reads) else report_mismatch("bus reads", exp_reads, bus_reads);
    end
  endtask

  always @(negedge clk) begin : check_retire
    retire_t want;
    if (!rst && retire_valid && exp_q.size() != 0) begin
      want = exp_q.pop_front();
      assert (retire_pc == want.pc) else report_mismatch("retire pc", want.pc, retire_pc);
      assert (retire_rd == want.rd) else report_mismatch("retire rd", want.rd, retire_rd);
      assert (retire_data == want.data)
        else report_mismatch("retire data", want.data, retire_data);
    end
  end

  // Fills read word 0, then word 1 of the same line.
  always @(posedge clk) begin
    if (rst) begin
      second_word <= 1'b0;
      bus_reads   <= 0;
    end else if (imem_arvalid && imem_rvalid) begin
      bus_reads <= bus_reads + 1;
      if (!second_word) begin
        assert (imem_araddr[2:0] == 3'b000)
          else report_mismatch("fill word 0 address", {imem_araddr[31:3], 3'b000}, imem_araddr);
        line_base <= imem_araddr;
      end else begin
        assert (imem_araddr == line_base + 32'd4)
          else report_mismatch("fill word 1 address", line_base + 32'd4, imem_araddr);
      end
      second_word <= !second_word;
    end
  end

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    mismatches = 0;
    timeouts   = 0;
    wr_pc      = 32'd0;
    test_name  = "reset";

    begin_test("arith");
    step(lui(5'd1, 20'h12345), 5'd1, 32'h1234_5000);
    step(addi(5'd1, 5'd1, 12'h678), 5'd1, 32'h1234_5678);  // Needs the bypass.
    step(addi(5'd2, 5'd0, 12'hff0), 5'd2, 32'hffff_fff0);
    step(rtype(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'h1234_5668);
    step(rtype(7'h20, 3'b000, 5'd4, 5'd3, 5'd1), 5'd4, 32'hffff_fff0);
    step(rtype(7'h00, 3'b111, 5'd5, 5'd1, 5'd2), 5'd5, 32'h1234_5670);
    step(rtype(7'h00, 3'b110, 5'd6, 5'd5, 5'd3), 5'd6, 32'h1234_5678);
    step(rtype(7'h00, 3'b100, 5'd7, 5'd6, 5'd1), 5'd7, 32'h0);
    step(rtype(7'h00, 3'b010, 5'd8, 5'd2, 5'd1), 5'd8, 32'h1);
    step(rtype(7'h00, 3'b010, 5'd9, 5'd1, 5'd2), 5'd9, 32'h0);
    step(jal(5'd0, 21'd0), 5'd0, 32'h0);
    release_reset();
    drain(-1);

    begin_test("branch");
    step(addi(5'd1, 5'd0, 12'd5), 5'd1, 32'd5);
    step(addi(5'd2, 5'd0, -12'd3), 5'd2, 32'hffff_fffd);
    step(addi(5'd3, 5'd0, 12'd5), 5'd3, 32'd5);
    step(addi(5'd10, 5'd0, 12'd100), 5'd10, 32'd100);
    step(branch(3'b000, 5'd1, 5'd3, 13'd8), 5'd0, 32'd0);  // BEQ taken.
    put(addi(5'd10, 5'd0, 12'd1));
    step(branch(3'b000, 5'd1, 5'd2, 13'd8), 5'd0, 32'd0);
    step(branch(3'b001, 5'd1, 5'd2, 13'd8), 5'd0, 32'd0);  // BNE taken.
    put(addi(5'd10, 5'd0, 12'd2));
    step(branch(3'b001, 5'd1, 5'd3, 13'd8), 5'd0, 32'd0);
    step(branch(3'b100, 5'd2, 5'd1, 13'd8), 5'd0, 32'd0);  // BLT taken.
    put(addi(5'd10, 5'd0, 12'd3));
    step(branch(3'b100, 5'd1, 5'd2, 13'd8), 5'd0, 32'd0);
    step(branch(3'b101, 5'd1, 5'd2, 13'd8), 5'd0, 32'd0);  // BGE taken.
    put(addi(5'd10, 5'd0, 12'd4));
    step(branch(3'b101, 5'd2, 5'd1, 13'd8), 5'd0, 32'd0);
    step(addi(5'd11, 5'd0, 12'd7), 5'd11, 32'd7);
    step(rtype(7'h00, 3'b000, 5'd12, 5'd10, 5'd11), 5'd12, 32'd107);
    step(jal(5'd0, 21'd0), 5'd0, 32'd0);
    release_reset();
    drain(-1);

    begin_test("jump");
    step(jal(5'd1, 21'd12), 5'd1, 32'd4);
    put(addi(5'd5, 5'd0, 12'd1));
    put(addi(5'd5, 5'd0, 12'd2));
    step(addi(5'd2, 5'd0, 12'd40), 5'd2, 32'd40);
    step(itype(7'b1100111, 5'd3, 3'b000, 5'd2, 12'd4), 5'd3, 32'd20);  // JALR to 44.
    put(addi(5'd5, 5'd0, 12'd3));
    wr_pc = 32'd44;
    step(jal(5'd7, -21'd20), 5'd7, 32'd48);
    put(addi(5'd5, 5'd0, 12'd4));
    wr_pc = 32'd24;
    step(addi(5'd8, 5'd0, 12'd9), 5'd8, 32'd9);
    step(jal(5'd0, 21'd0), 5'd0, 32'd0);
    release_reset();
    drain(-1);

    begin_test("loop");
    step(addi(5'd1, 5'd0, 12'd0), 5'd1, 32'd0);
    step(addi(5'd2, 5'd0, 12'd3), 5'd2, 32'd3);
    put(addi(5'd1, 5'd1, 12'd5));
    put(addi(5'd2, 5'd2, -12'd1));
    put(branch(3'b001, 5'd2, 5'd0, -13'd8));
    put(jal(5'd0, 21'd0));
    for (int i = 1; i <= 3; i++) begin
      expect_retire(32'd8, 5'd1, 32'(5 * i));
      expect_retire(32'd12, 5'd2, 32'(3 - i));
      expect_retire(32'd16, 5'd0, 32'd0);
    end
    expect_retire(32'd20, 5'd0, 32'd0);
    release_reset();
    drain(6);  // Three lines, each filled once.

    begin_test("fence_i");
    step(addi(5'd2, 5'd0, 12'd0), 5'd2, 32'd0);
    step(addi(5'd1, 5'd0, 12'd1), 5'd1, 32'd1);
    step(branch(3'b001, 5'd2, 5'd0, 13'd16), 5'd0, 32'd0);
    step(addi(5'd2, 5'd0, 12'd1), 5'd2, 32'd1);
    step(itype(7'b0001111, 5'd0, 3'b001, 5'd0, 12'd0), 5'd0, 32'd0);
    step(jal(5'd0, -21'd16), 5'd0, 32'd0);
    put(jal(5'd0, 21'd0));
    expect_retire(32'd4, 5'd1, 32'd7);
    expect_retire(32'd8, 5'd0, 32'd0);
    expect_retire(32'd24, 5'd0, 32'd0);
    release_reset();
    wait_retire_pc(32'd4);
    u_imem.write_word(32'd4, addi(5'd1, 5'd0, 12'd7));  // Line 0 is cached by now.
    drain(-1);

    begin_test("unsupported");
    step(addi(5'd1, 5'd0, 12'd11), 5'd1, 32'd11);
    step(32'h0000_008b, 5'd0, 32'd0);
    step(itype(7'b0010011, 5'd1, 3'b110, 5'd1, 12'h0ff), 5'd0, 32'd0);
    step(itype(7'b0000011, 5'd1, 3'b010, 5'd0, 12'd0), 5'd0, 32'd0);
    step(rtype(7'h00, 3'b001, 5'd1, 5'd1, 5'd1), 5'd0, 32'd0);
    step(rtype(7'h01, 3'b000, 5'd1, 5'd1, 5'd1), 5'd0, 32'd0);
    step(rtype(7'h00, 3'b000, 5'd2, 5'd1, 5'd0), 5'd2, 32'd11);
    step(jal(5'd0, 21'd0), 5'd0, 32'd0);
    release_reset();
    drain(-1);

    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== tb/imem_model.sv ====
`timescale 1ns/1ns

module imem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o
);

  localparam int DEPTH = 256;

  logic [31:0] mem [DEPTH];
  logic        busy;
  int unsigned delay;

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    mem[addr[9:2]] = data;
  endtask

  // Each read answers after 1 to 4 cycles, rvalid high for one cycle.
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = {24'(i), 8'h0b};  // Custom-0 opcode.
    end
    rdata_o  = '0;
    rvalid_o = 1'b0;
    busy     = 1'b0;
    delay    = $urandom(32'hcc02_ccae);
    delay    = 0;
    forever begin
      @(negedge clk);
      if (rst || rvalid_o) begin
        rvalid_o <= 1'b0;
        busy = 1'b0;
      end else if (arvalid_i) begin
        if (!busy) begin
          busy  = 1'b1;
          delay = ($urandom % 4) + 1;
        end
        delay = delay - 1;
        if (delay == 0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[araddr_i[9:2]];
          busy = 1'b0;
        end
      end
    end
  end

endmodule

// ==== source/core_top.sv ====
`timescale 1ns/1ns

module core_top import core_pkg::*; (
  input  logic     clk,
  input  logic     rst,

  output addr_t    imem_araddr_o,
  output logic     imem_arvalid_o,
  input  word_t    imem_rdata_i,
  input  logic     imem_rvalid_i,

  output logic     retire_valid_o,
  output addr_t    retire_pc_o,
  output reg_idx_t retire_rd_o,
  output word_t    retire_data_o
);

  reg_idx_t rf_rs1;
  reg_idx_t rf_rs2;
  word_t    rf_rdata1;
  word_t    rf_rdata2;

  fetch_if    u_fetch_if ();
  stage_if    u_dec_stage ();
  stage_if    u_res_stage ();
  redirect_if u_redirect_if ();

  ifu u_ifu (
    .clk            (clk),
    .rst            (rst),
    .imem_araddr_o  (imem_araddr_o),
    .imem_arvalid_o (imem_arvalid_o),
    .imem_rdata_i   (imem_rdata_i),
    .imem_rvalid_i  (imem_rvalid_i),
    .fetch          (u_fetch_if.source),
    .redirect       (u_redirect_if.sink)
  );

  decode u_decode (
    .clk   (clk),
    .rst   (rst),
    .fetch (u_fetch_if.sink),
    .dec   (u_dec_stage.source)
  );

  execute u_execute (
    .clk         (clk),
    .rst         (rst),
    .dec         (u_dec_stage.sink),
    .res         (u_res_stage.source),
    .redirect    (u_redirect_if.source),
    .rf_rs1_o    (rf_rs1),
    .rf_rs2_o    (rf_rs2),
    .rf_rdata1_i (rf_rdata1),
    .rf_rdata2_i (rf_rdata2)
  );

  result u_result (
    .clk            (clk),
    .rst            (rst),
    .res            (u_res_stage.sink),
    .rf_rs1_i       (rf_rs1),
    .rf_rs2_i       (rf_rs2),
    .rf_rdata1_o    (rf_rdata1),
    .rf_rdata2_o    (rf_rdata2),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

endmodule

// ==== source/result.sv ====
`timescale 1ns/1ns

module result import core_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  stage_if.sink    res,

  input  reg_idx_t rf_rs1_i,
  input  reg_idx_t rf_rs2_i,
  output word_t    rf_rdata1_o,
  output word_t    rf_rdata2_o,

  output logic     retire_valid_o,
  output addr_t    retire_pc_o,
  output reg_idx_t retire_rd_o,
  output word_t    retire_data_o
);

  word_t regs [31:1];  // x0 is not stored.
  logic  wr_en;

  assign wr_en = res.valid && res.wen && (res.rd != '0);

  assign rf_rdata1_o = (rf_rs1_i == '0) ? '0 : regs[rf_rs1_i];
  assign rf_rdata2_o = (rf_rs2_i == '0) ? '0 : regs[rf_rs2_i];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[res.rd] <= res.result;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= res.valid;
    end
  end

  // Entries that write nothing report rd 0.
  always_ff @(posedge clk) begin
    retire_pc_o   <= res.pc;
    retire_rd_o   <= wr_en ? res.rd : '0;
    retire_data_o <= wr_en ? res.result : '0;
  end

endmodule

// ==== source/execute.sv ====
`timescale 1ns/1ns

module execute import core_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  stage_if.sink      dec,
  stage_if.source    res,
  redirect_if.source redirect,
  output reg_idx_t   rf_rs1_o,
  output reg_idx_t   rf_rs2_o,
  input  word_t      rf_rdata1_i,
  input  word_t      rf_rdata2_i
);

  word_t op_a;
  word_t rs2_val;
  word_t op_b;
  word_t alu_out;
  word_t result_d;
  addr_t link;
  addr_t jump_base;
  addr_t jump_tgt;
  addr_t next_pc;
  logic  fwd_ok;
  logic  is_jump;
  logic  taken;

  assign rf_rs1_o = dec.rs1;
  assign rf_rs2_o = dec.rs2;

  // Older entry in result is not yet in the register file.
  assign fwd_ok  = res.valid && res.wen && (res.rd != '0);
  assign op_a    = (fwd_ok && res.rd == dec.rs1) ? res.result : rf_rdata1_i;
  assign rs2_val = (fwd_ok && res.rd == dec.rs2) ? res.result : rf_rdata2_i;
  assign op_b    = (dec.rs2 == '0) ? dec.imm : rs2_val;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    alu_out = op_a + op_b;
      ALU_SUB:    alu_out = op_a - op_b;
      ALU_AND:    alu_out = op_a & op_b;
      ALU_OR:     alu_out = op_a | op_b;
      ALU_XOR:    alu_out = op_a ^ op_b;
      ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(op_b));
      ALU_PASS_B: alu_out = op_b;
      default:    alu_out = op_a + op_b;
    endcase
  end

  always_comb begin
    case (dec.br_kind)
      BR_JAL, BR_JALR: taken = 1'b1;
      BR_EQ:           taken = (op_a == rs2_val);
      BR_NE:           taken = (op_a != rs2_val);
      BR_LT:           taken = ($signed(op_a) < $signed(rs2_val));
      BR_GE:           taken = ($signed(op_a) >= $signed(rs2_val));
      default:         taken = 1'b0;
    endcase
  end

  assign is_jump   = (dec.br_kind == BR_JAL) || (dec.br_kind == BR_JALR);
  assign link      = dec.pc + addr_t'(4);
  assign jump_base = (dec.br_kind == BR_JALR) ? op_a : dec.pc;
  assign jump_tgt  = (jump_base + dec.imm) & ~addr_t'(1);
  assign next_pc   = taken ? jump_tgt : link;
  assign result_d  = is_jump ? link : alu_out;

  always_ff @(posedge clk) begin
    if (rst) begin
      res.valid      <= 1'b0;
      redirect.valid <= 1'b0;
    end else begin
      res.valid      <= dec.valid;
      redirect.valid <= dec.valid && ((dec.br_kind != BR_NONE) || dec.fence);
    end
  end

  always_ff @(posedge clk) begin
    res.alu_op      <= dec.alu_op;
    res.br_kind     <= dec.br_kind;
    res.rd          <= dec.rd;
    res.rs1         <= dec.rs1;
    res.rs2         <= dec.rs2;
    res.imm         <= dec.imm;
    res.pc          <= dec.pc;
    res.wen         <= dec.wen;
    res.fence       <= dec.fence;
    res.result      <= result_d;
    redirect.target <= next_pc;  // pc+4 when untaken or FENCE.I.
    redirect.fence  <= dec.fence;
  end

endmodule

// ==== source/decode.sv ====
`timescale 1ns/1ns

module decode import core_pkg::*; (
  input logic     clk,
  input logic     rst,
  fetch_if.sink   fetch,
  stage_if.source dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm_b;
  alu_op_e    alu_op_d;
  br_kind_e   br_kind_d;
  reg_idx_t   rs1_d;
  reg_idx_t   rs2_d;
  word_t      imm_d;
  logic       wen_d;
  logic       fence_d;

  assign fetch.ready = 1'b1;  // Stages never stall.
  assign dec.result  = '0;    // Filled in by execute.

  assign opcode = fetch.inst[6:0];
  assign funct3 = fetch.inst[14:12];
  assign funct7 = fetch.inst[31:25];

  assign imm_i = {{20{fetch.inst[31]}}, fetch.inst[31:20]};
  assign imm_u = {fetch.inst[31:12], 12'b0};
  assign imm_j = {{12{fetch.inst[31]}}, fetch.inst[19:12], fetch.inst[20],
                  fetch.inst[30:21], 1'b0};
  assign imm_b = {{20{fetch.inst[31]}}, fetch.inst[7], fetch.inst[30:25],
                  fetch.inst[11:8], 1'b0};

  // rs2 of x0 makes execute take the immediate as operand b.
  always_comb begin
    alu_op_d  = ALU_ADD;
    br_kind_d = BR_NONE;
    rs1_d     = fetch.inst[19:15];
    rs2_d     = fetch.inst[24:20];
    imm_d     = '0;
    wen_d     = 1'b0;
    fence_d   = 1'b0;
    case (opcode)
      OP_LUI: begin
        alu_op_d = ALU_PASS_B;
        rs1_d    = '0;
        rs2_d    = '0;
        imm_d    = imm_u;
        wen_d    = 1'b1;
      end
      OP_IMM: begin
        rs2_d = '0;
        imm_d = imm_i;
        wen_d = (funct3 == F3_ADD_SUB);  // ADDI only.
      end
      OP_REG: begin
        wen_d = 1'b1;
        if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
          alu_op_d = ALU_SUB;
        end else if (funct7 != F7_BASE) begin
          wen_d = 1'b0;
        end else begin
          case (funct3)
            F3_ADD_SUB: alu_op_d = ALU_ADD;
            F3_AND:     alu_op_d = ALU_AND;
            F3_OR:      alu_op_d = ALU_OR;
            F3_XOR:     alu_op_d = ALU_XOR;
            F3_SLT:     alu_op_d = ALU_SLT;
            default:    wen_d = 1'b0;
          endcase
        end
      end
      OP_JAL: begin
        br_kind_d = BR_JAL;
        imm_d     = imm_j;
        wen_d     = 1'b1;
      end
      OP_JALR: begin
        imm_d = imm_i;
        if (funct3 == F3_JALR) begin
          br_kind_d = BR_JALR;
          wen_d     = 1'b1;
        end else begin
          // x0 != x0 never holds, so fetch resumes at pc+4.
          br_kind_d = BR_NE;
          rs1_d     = '0;
          rs2_d     = '0;
        end
      end
      OP_BRANCH: begin
        imm_d = imm_b;
        case (funct3)
          F3_BEQ:  br_kind_d = BR_EQ;
          F3_BNE:  br_kind_d = BR_NE;
          F3_BLT:  br_kind_d = BR_LT;
          F3_BGE:  br_kind_d = BR_GE;
          default: begin
            br_kind_d = BR_NE;  // Never taken.
            rs1_d     = '0;
            rs2_d     = '0;
          end
        endcase
      end
      OP_MISC_MEM: fence_d = (fetch.inst == INST_FENCE_I);
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= fetch.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch.valid) begin
      dec.alu_op  <= alu_op_d;
      dec.br_kind <= br_kind_d;
      dec.rd      <= fetch.inst[11:7];
      dec.rs1     <= rs1_d;
      dec.rs2     <= rs2_d;
      dec.imm     <= imm_d;
      dec.pc      <= fetch.pc;
      dec.wen     <= wen_d;
      dec.fence   <= fence_d;
    end
  end

endmodule

// ==== source/ifu.sv ====
`timescale 1ns/1ns

module ifu import core_pkg::*, cache_pkg::*; (
  input  logic  clk,
  input  logic  rst,

  output addr_t imem_araddr_o,
  output logic  imem_arvalid_o,
  input  word_t imem_rdata_i,
  input  logic  imem_rvalid_i,

  fetch_if.source  fetch,
  redirect_if.sink redirect
);

  addr_t       pc_q;
  logic        stall_q;  // Waiting for execute to resolve.
  fill_state_e fill_q;

  logic [L1I_LINES-1:0] l1i_valid;
  l1i_tag_t             l1i_tag [L1I_LINES];
  word_t                l1i_data [L1I_LINES][L1I_LINE_WORDS];

  l1i_tag_t   pc_tag;
  l1i_idx_t   pc_idx;
  l1i_off_t   pc_off;
  l1i_off_t   fill_off;
  logic       hit;
  logic       handoff;
  logic       is_ctrl;
  logic [6:0] opcode;

  assign pc_tag = pc_q[$bits(addr_t)-1 -: L1I_TAG_W];
  assign pc_idx = pc_q[L1I_BYTE_W+L1I_OFF_W +: L1I_IDX_W];
  assign pc_off = pc_q[L1I_BYTE_W +: L1I_OFF_W];

  // No hits while a fill owns the arrays.
  assign hit = (fill_q == FILL_IDLE) && l1i_valid[pc_idx] &&
               (l1i_tag[pc_idx] == pc_tag);

  assign fetch.valid = hit && !stall_q;
  assign fetch.inst  = l1i_data[pc_idx][pc_off];
  assign fetch.pc    = pc_q;

  assign handoff = fetch.valid && fetch.ready;

  // Anything execute has to redirect for.
  assign opcode  = fetch.inst[6:0];
  assign is_ctrl = (opcode == OP_JAL) || (opcode == OP_JALR) ||
                   (opcode == OP_BRANCH) || (fetch.inst == INST_FENCE_I);

  assign fill_off       = l1i_off_t'(fill_q == FILL_WORD1);
  assign imem_arvalid_o = (fill_q == FILL_WORD0) || (fill_q == FILL_WORD1);
  assign imem_araddr_o  = {pc_q[$bits(addr_t)-1:L1I_BYTE_W+L1I_OFF_W], fill_off,
                           {L1I_BYTE_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q      <= PC_INIT;
      stall_q   <= 1'b0;
      fill_q    <= FILL_IDLE;
      l1i_valid <= '0;
    end else begin
      if (redirect.valid) begin
        pc_q    <= redirect.target;
        stall_q <= 1'b0;
      end else if (handoff) begin
        if (is_ctrl) begin
          stall_q <= 1'b1;
        end else begin
          pc_q <= pc_q + addr_t'(4);
        end
      end

      case (fill_q)
        FILL_IDLE: begin
          if (!hit && !stall_q) begin
            fill_q <= FILL_WORD0;
          end
        end
        FILL_WORD0: begin
          if (imem_rvalid_i) begin
            fill_q            <= FILL_WORD1;
            l1i_valid[pc_idx] <= 1'b0;  // Tag now belongs to the new line.
          end
        end
        FILL_WORD1: begin
          if (imem_rvalid_i) begin
            fill_q            <= FILL_DONE;
            l1i_valid[pc_idx] <= 1'b1;
          end
        end
        FILL_DONE: fill_q <= FILL_IDLE;
        default:   fill_q <= FILL_IDLE;
      endcase

      // FENCE.I drops every line.
      if (redirect.valid && redirect.fence) begin
        l1i_valid <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (imem_arvalid_o && imem_rvalid_i) begin
      l1i_data[pc_idx][fill_off] <= imem_rdata_i;
      if (fill_q == FILL_WORD0) begin
        l1i_tag[pc_idx] <= pc_tag;
      end
    end
  end

endmodule

// ==== source/pipe_if.sv ====
`timescale 1ns/1ns

interface fetch_if import core_pkg::*; ();
  logic  valid;
  logic  ready;
  inst_t inst;
  addr_t pc;

  modport source (output valid, output inst, output pc, input ready);
  modport sink (input valid, input inst, input pc, output ready);
endinterface

interface stage_if import core_pkg::*; ();
  logic     valid;
  alu_op_e  alu_op;
  br_kind_e br_kind;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    imm;
  addr_t    pc;
  logic     wen;
  logic     fence;
  word_t    result;  // Only meaningful after execute.

  modport source (
    output valid, alu_op, br_kind, rd, rs1, rs2, imm, pc, wen, fence, result
  );
  modport sink (
    input valid, alu_op, br_kind, rd, rs1, rs2, imm, pc, wen, fence, result
  );
endinterface

interface redirect_if import core_pkg::*; ();
  logic  valid;
  addr_t target;
  logic  fence;

  modport source (output valid, output target, output fence);
  modport sink (input valid, input target, input fence);
endinterface

// ==== source/cache_pkg.sv ====
package cache_pkg;

  // Direct mapped, 4 lines of 2 words.
  localparam int L1I_LINES      = 4;
  localparam int L1I_LINE_WORDS = 2;

  localparam int L1I_BYTE_W = 2;  // Byte within a word.
  localparam int L1I_IDX_W  = $clog2(L1I_LINES);
  localparam int L1I_OFF_W  = $clog2(L1I_LINE_WORDS);
  localparam int L1I_TAG_W  = 32 - L1I_IDX_W - L1I_OFF_W - L1I_BYTE_W;

  typedef logic [L1I_TAG_W-1:0] l1i_tag_t;
  typedef logic [L1I_IDX_W-1:0] l1i_idx_t;
  typedef logic [L1I_OFF_W-1:0] l1i_off_t;

  // Line fill, word 0 first.
  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_WORD0,
    FILL_WORD1,
    FILL_DONE
  } fill_state_e;

endpackage

// ==== source/core_pkg.sv ====
package core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // Major opcodes, inst[6:0].
  localparam logic [6:0] OP_LUI      = 7'b0110111;
  localparam logic [6:0] OP_IMM      = 7'b0010011;
  localparam logic [6:0] OP_REG      = 7'b0110011;
  localparam logic [6:0] OP_JAL      = 7'b1101111;
  localparam logic [6:0] OP_JALR     = 7'b1100111;
  localparam logic [6:0] OP_BRANCH   = 7'b1100011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_JALR    = 3'b000;

  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  localparam inst_t INST_FENCE_I = 32'h0000_100f;
  localparam addr_t PC_INIT      = 32'h0000_0000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_JAL,
    BR_JALR,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE
  } br_kind_e;

endpackage
